/* mfp_timers_top.f */
src/mfp_timer_pkg.sv
src/mfp_reg_pkg.sv
src/mfp_prescaler.sv
src/mfp_timer.sv
src/mfp_timer_regs.sv
src/mfp_timer_irq.sv
src/mfp_timers_top.sv
verification/tb_clock_gen.sv
verification/mfp_timers_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mfp_timers_tb
FILELIST  ?= mfp_timers_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Result: PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/mfp_timers_tb.sv */
`timescale 1ns/1ps

module mfp_timers_tb;
  import mfp_reg_pkg::*;
  import mfp_timer_pkg::*;

  // one table row, expected values filled in by make_row
  typedef struct packed {
    logic [1:0]  tmr;
    logic [3:0]  mode;
    logic [7:0]  data;
    logic [15:0] pulses;
    logic [7:0]  exp_cnt;
    logic        exp_tout;
    logic        exp_pend;
  } row_t;

  logic                  CLK;
  logic                  arst_n;
  logic                  we;
  logic [ADDR_W-1:0]     addr;
  logic [DATA_W-1:0]     wdata;
  logic                  xclk;
  logic                  tai;
  logic                  tbi;
  logic [DATA_W-1:0]     rdata;
  logic [NUM_TIMERS-1:0] tout;
  logic                  irq;

  row_t        rows[$];
  logic [31:0] lfsr = 32'h45daafe4;
  longint      limit_ns = 0;

  tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(2)) u_clock_gen (.CLK(CLK), .arst_n(arst_n));

  mfp_timers_top mfp_timers_top_inst (.*);

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic expect_equal(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%02h, expected 0x%02h", name, got, exp));
    end
  endtask

  // taps 32, 22, 2, 1
  function automatic logic [31:0] next_lfsr(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // 2 to 5 cycles, two lfsr bits
  task automatic draw_width(output int w);
    logic [1:0] b;
    for (int i = 0; i < 2; i++) begin
      lfsr = next_lfsr(lfsr);
      b[i] = lfsr[0];
    end
    w = 2 + int'(b);
  endtask

  // all bus tasks start and end on a falling edge
  task automatic write_reg(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    we    = 1'b1;
    addr  = a;
    wdata = d;
    @(negedge CLK);
    we = 1'b0;
    @(negedge CLK);
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] a, output logic [DATA_W-1:0] d);
    addr = a;
    @(negedge CLK);
    d = rdata;
  endtask

  // which is {tbi, tai, xclk}
  task automatic pulse_inputs(input logic [2:0] which, input int n);
    int hi;
    int lo;
    for (int p = 0; p < n; p++) begin
      draw_width(hi);
      draw_width(lo);
      {tbi, tai, xclk} = which;
      repeat (hi) @(negedge CLK);
      {tbi, tai, xclk} = 3'b000;
      repeat (lo) @(negedge CLK);
    end
  endtask

  function automatic row_t make_row(input logic [1:0] tmr, input logic [3:0] mode,
                                    input logic [7:0] data, input int pulses);
    row_t r;
    int   ticks;
    int   n;
    int   toggles;
    r.tmr    = tmr;
    r.mode   = mode;
    r.data   = data;
    r.pulses = 16'(pulses);
    if (mode == MODE_EVENT) begin
      ticks = pulses;
    end else begin
      ticks = pulses / int'(PSC_DIV[mode[PSC_SEL_W-1:0]]);
    end
    // data 0 counts as 256
    n          = (data == 8'd0) ? 256 : int'(data);
    toggles    = ticks / n;
    r.exp_cnt  = 8'(n - (ticks % n));
    r.exp_tout = toggles[0];
    r.exp_pend = (toggles > 0);
    return r;
  endfunction

  task automatic build_table();
    rows.push_back(make_row(2'd0, 4'd1, 8'd5, 13));
    rows.push_back(make_row(2'd0, 4'd2, 8'd3, 20));
    rows.push_back(make_row(2'd1, 4'd3, 8'd0, 45));
    rows.push_back(make_row(2'd1, 4'd4, 8'd2, 50));
    rows.push_back(make_row(2'd0, 4'd5, 8'd1, 160));
    rows.push_back(make_row(2'd1, 4'd6, 8'd2, 210));
    rows.push_back(make_row(2'd0, MODE_EVENT, 8'd4, 9));
    rows.push_back(make_row(2'd1, MODE_EVENT, 8'd7, 7));
    // C and D share one TCDCR write and the same pulses
    rows.push_back(make_row(2'd2, 4'd1, 8'd6, 20));
    rows.push_back(make_row(2'd3, 4'd2, 8'd2, 20));
  endtask

  task automatic check_timer(input row_t r, input bit stopped);
    logic [7:0] got;
    read_reg(ADDR_TADR + 3'(r.tmr), got);
    expect_equal($sformatf("rdata (counter %0d)", r.tmr), got, r.exp_cnt);
    if (stopped && r.tmr < 2'd2) begin
      expect_equal($sformatf("tout[%0d]", r.tmr), 8'(tout[r.tmr]), 8'h00);
    end else begin
      expect_equal($sformatf("tout[%0d]", r.tmr), 8'(tout[r.tmr]), 8'(r.exp_tout));
    end
    if (!stopped) begin
      read_reg(ADDR_ISR, got);
      expect_equal($sformatf("pending[%0d]", r.tmr), 8'(got[r.tmr]), 8'(r.exp_pend));
    end
  endtask

  // one row for A or B, two rows for the C/D pair
  task automatic apply_group(input int first, input int cnt);
    row_t              r;
    ctrl_byte_u        cb;
    logic [3:0]        mask;
    logic [3:0]        pend_bits;
    logic [2:0]        which;
    logic [ADDR_W-1:0] ctrl_addr;
    logic [7:0]        got;
    logic              exp_irq;
    r         = rows[first];
    mask      = '0;
    pend_bits = '0;
    exp_irq   = 1'b0;
    for (int k = 0; k < cnt; k++) begin
      mask[rows[first + k].tmr]      = 1'b1;
      pend_bits[rows[first + k].tmr] = rows[first + k].exp_pend;
      exp_irq = exp_irq | rows[first + k].exp_pend;
      write_reg(ADDR_TADR + 3'(rows[first + k].tmr), rows[first + k].data);
    end
    // unmask this group, drop old pending bits
    write_reg(ADDR_ISR, {mask, 4'hF});
    cb = '0;
    if (cnt == 1) begin
      ctrl_addr  = (r.tmr == 2'd0) ? ADDR_TACR : ADDR_TBCR;
      cb.ab.mode = r.mode;
      write_reg(ctrl_addr, cb);
      read_reg(ctrl_addr, got);
      expect_equal("rdata (TxCR)", got, {4'h0, r.mode});
    end else begin
      ctrl_addr   = ADDR_TCDCR;
      cb.cd.c_psc = r.mode[PSC_SEL_W-1:0];
      cb.cd.d_psc = rows[first + 1].mode[PSC_SEL_W-1:0];
      write_reg(ctrl_addr, cb);
      read_reg(ctrl_addr, got);
      expect_equal("rdata (TCDCR)", got, cb);
    end
    if (r.mode == MODE_EVENT) begin
      which = (r.tmr == 2'd0) ? 3'b010 : 3'b100;
    end else begin
      which = 3'b001;
    end
    pulse_inputs(which, int'(r.pulses));
    // event rows then run xclk alone, which must not count
    if (r.mode == MODE_EVENT) begin
      pulse_inputs(3'b001, int'(r.pulses));
    end
    repeat (8) @(negedge CLK);
    for (int k = 0; k < cnt; k++) begin
      check_timer(rows[first + k], 1'b0);
    end
    expect_equal("irq", 8'(irq), 8'(exp_irq));
    // masked, the pending bits stay and irq drops
    write_reg(ADDR_ISR, 8'h00);
    read_reg(ADDR_ISR, got);
    expect_equal("rdata (ISR)", got, {4'h0, pend_bits});
    expect_equal("irq", 8'(irq), 8'h00);
    write_reg(ADDR_ISR, {mask, 4'hF});
    read_reg(ADDR_ISR, got);
    expect_equal("rdata (ISR)", got, {mask, 4'h0});
    expect_equal("irq", 8'(irq), 8'h00);
    // stop, A/B outputs cleared, counters must hold
    cb = '0;
    if (cnt == 1) begin
      cb.ab.tout_reset = 1'b1;
    end
    write_reg(ctrl_addr, cb);
    pulse_inputs(3'b111, 3);
    repeat (8) @(negedge CLK);
    for (int k = 0; k < cnt; k++) begin
      check_timer(rows[first + k], 1'b1);
    end
  endtask

  initial begin
    int         i;
    int         total;
    logic [7:0] got;
    we    = 1'b0;
    addr  = '0;
    wdata = '0;
    xclk  = 1'b0;
    tai   = 1'b0;
    tbi   = 1'b0;
    build_table();
    // up to 10 cycles per pulse, 3 extra pulses and overhead per row
    total = 0;
    foreach (rows[k]) begin
      total += int'(rows[k].pulses) + 3;
      // event rows pulse xclk alone as well
      if (rows[k].mode == MODE_EVENT) begin
        total += int'(rows[k].pulses);
      end
    end
    limit_ns = longint'(total) * 80 + longint'(rows.size()) * 1600 + 2000;
    wait (arst_n === 1'b1);
    @(negedge CLK);
    for (int a = 0; a < 8; a++) begin
      read_reg(3'(a), got);
      expect_equal($sformatf("rdata (addr %0d)", a), got, 8'h00);
    end
    expect_equal("tout", 8'(tout), 8'h00);
    expect_equal("irq", 8'(irq), 8'h00);
    i = 0;
    while (i < rows.size()) begin
      if (rows[i].tmr == 2'd2) begin
        apply_group(i, 2);
        i += 2;
      end else begin
        apply_group(i, 1);
        i += 1;
      end
    end
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    abort_run($sformatf("watchdog expired after %0d ns, tests did not finish", limit_ns));
  end

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic CLK,
  output logic arst_n
);

  initial begin
    CLK = 1'b0;
    forever #(PERIOD_NS / 2) CLK = ~CLK;
  end

  // release on a falling edge, away from the active edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge CLK);
    arst_n = 1'b1;
  end

endmodule

/* src/mfp_timers_top.sv */
`timescale 1ns/1ps

module mfp_timers_top (
  input  logic                                 CLK,
  input  logic                                 arst_n,
  input  logic                                 we,
  input  logic [mfp_reg_pkg::ADDR_W-1:0]       addr,
  input  logic [mfp_reg_pkg::DATA_W-1:0]       wdata,
  input  logic                                 xclk,
  input  logic                                 tai,
  input  logic                                 tbi,
  output logic [mfp_reg_pkg::DATA_W-1:0]       rdata,
  output logic [mfp_timer_pkg::NUM_TIMERS-1:0] tout,
  output logic                                 irq
);
  import mfp_reg_pkg::*;
  import mfp_timer_pkg::*;

  logic [NUM_TIMERS-1:0] data_we;
  logic [NUM_TIMERS-1:0] ctrl_we;
  logic [NUM_TIMERS-1:0] timeout;
  logic [MODE_W-1:0]     mode_a, mode_b, mode_c, mode_d;
  logic [MODE_W-1:0]     mode_q_a, mode_q_b, mode_q_c, mode_q_d;
  logic [DATA_W-1:0]     count_q_a, count_q_b, count_q_c, count_q_d;
  logic                  tout_reset;
  logic                  isr_we;
  logic [DATA_W-1:0]     irq_status;

  mfp_timer_regs u_regs (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .we         (we),
    .addr       (addr),
    .wdata      (wdata),
    .rdata      (rdata),
    .data_we    (data_we),
    .ctrl_we    (ctrl_we),
    .mode_a     (mode_a),
    .mode_b     (mode_b),
    .mode_c     (mode_c),
    .mode_d     (mode_d),
    .tout_reset (tout_reset),
    .isr_we     (isr_we),
    .count_q_a  (count_q_a),
    .count_q_b  (count_q_b),
    .count_q_c  (count_q_c),
    .count_q_d  (count_q_d),
    .mode_q_a   (mode_q_a),
    .mode_q_b   (mode_q_b),
    .mode_q_c   (mode_q_c),
    .mode_q_d   (mode_q_d),
    .tout       (tout),
    .irq_status (irq_status)
  );

  // A and B take external triggers
  mfp_timer #(.HAS_EVENT(1'b1)) u_timer_a (
    .CLK (CLK), .arst_n (arst_n),
    .data_we (data_we[0]), .data (wdata),
    .ctrl_we (ctrl_we[0]), .mode (mode_a), .tout_reset (tout_reset),
    .xclk (xclk), .trig (tai),
    .count_q (count_q_a), .mode_q (mode_q_a), .tout (tout[0]), .timeout (timeout[0])
  );

  mfp_timer #(.HAS_EVENT(1'b1)) u_timer_b (
    .CLK (CLK), .arst_n (arst_n),
    .data_we (data_we[1]), .data (wdata),
    .ctrl_we (ctrl_we[1]), .mode (mode_b), .tout_reset (tout_reset),
    .xclk (xclk), .trig (tbi),
    .count_q (count_q_b), .mode_q (mode_q_b), .tout (tout[1]), .timeout (timeout[1])
  );

  // C and D are delay only
  mfp_timer #(.HAS_EVENT(1'b0)) u_timer_c (
    .CLK (CLK), .arst_n (arst_n),
    .data_we (data_we[2]), .data (wdata),
    .ctrl_we (ctrl_we[2]), .mode (mode_c), .tout_reset (tout_reset),
    .xclk (xclk), .trig (1'b0),
    .count_q (count_q_c), .mode_q (mode_q_c), .tout (tout[2]), .timeout (timeout[2])
  );

  mfp_timer #(.HAS_EVENT(1'b0)) u_timer_d (
    .CLK (CLK), .arst_n (arst_n),
    .data_we (data_we[3]), .data (wdata),
    .ctrl_we (ctrl_we[3]), .mode (mode_d), .tout_reset (tout_reset),
    .xclk (xclk), .trig (1'b0),
    .count_q (count_q_d), .mode_q (mode_q_d), .tout (tout[3]), .timeout (timeout[3])
  );

  mfp_timer_irq u_irq (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .timeout    (timeout),
    .isr_we     (isr_we),
    .wdata      (wdata),
    .irq_status (irq_status),
    .irq        (irq)
  );

endmodule

/* src/mfp_timer_irq.sv */
`timescale 1ns/1ps

module mfp_timer_irq (
  input  logic                                 CLK,
  input  logic                                 arst_n,
  input  logic [mfp_timer_pkg::NUM_TIMERS-1:0] timeout,
  input  logic                                 isr_we,
  input  logic [mfp_reg_pkg::DATA_W-1:0]       wdata,
  output logic [mfp_reg_pkg::DATA_W-1:0]       irq_status,
  output logic                                 irq
);
  import mfp_timer_pkg::*;

  logic [NUM_TIMERS-1:0] pending;
  logic [NUM_TIMERS-1:0] mask;
  logic [NUM_TIMERS-1:0] clr;

  // low nibble of an ISR write, 1 clears
  assign clr = isr_we ? wdata[NUM_TIMERS-1:0] : '0;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pending <= '0;
    end else begin
      // a timeout in the clear cycle still sets its bit
      pending <= (pending & ~clr) | timeout;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      mask <= '0;
    end else if (isr_we) begin
      mask <= wdata[NUM_TIMERS +: NUM_TIMERS];
    end
  end

  assign irq_status = {mask, pending};

  // any unmasked pending timeout
  assign irq = |(pending & mask);

endmodule

/* src/mfp_timer_regs.sv */
`timescale 1ns/1ps

module mfp_timer_regs (
  input  logic                                 CLK,
  input  logic                                 arst_n,
  input  logic                                 we,
  input  logic [mfp_reg_pkg::ADDR_W-1:0]       addr,
  input  logic [mfp_reg_pkg::DATA_W-1:0]       wdata,
  output logic [mfp_reg_pkg::DATA_W-1:0]       rdata,
  output logic [mfp_timer_pkg::NUM_TIMERS-1:0] data_we,
  output logic [mfp_timer_pkg::NUM_TIMERS-1:0] ctrl_we,
  output logic [mfp_timer_pkg::MODE_W-1:0]     mode_a,
  output logic [mfp_timer_pkg::MODE_W-1:0]     mode_b,
  output logic [mfp_timer_pkg::MODE_W-1:0]     mode_c,
  output logic [mfp_timer_pkg::MODE_W-1:0]     mode_d,
  output logic                                 tout_reset,
  output logic                                 isr_we,
  input  logic [mfp_reg_pkg::DATA_W-1:0]       count_q_a,
  input  logic [mfp_reg_pkg::DATA_W-1:0]       count_q_b,
  input  logic [mfp_reg_pkg::DATA_W-1:0]       count_q_c,
  input  logic [mfp_reg_pkg::DATA_W-1:0]       count_q_d,
  input  logic [mfp_timer_pkg::MODE_W-1:0]     mode_q_a,
  input  logic [mfp_timer_pkg::MODE_W-1:0]     mode_q_b,
  input  logic [mfp_timer_pkg::MODE_W-1:0]     mode_q_c,
  input  logic [mfp_timer_pkg::MODE_W-1:0]     mode_q_d,
  input  logic [mfp_timer_pkg::NUM_TIMERS-1:0] tout,
  input  logic [mfp_reg_pkg::DATA_W-1:0]       irq_status
);
  import mfp_reg_pkg::*;
  import mfp_timer_pkg::*;

  logic               wr_q;
  logic [ADDR_W-1:0]  addr_q;
  logic [DATA_W-1:0]  wdata_q;
  logic               wr;
  logic               wr_ab;
  ctrl_byte_u         wr_ctrl;
  ctrl_byte_u         cd_rd;

  // previous access, so that a held we acts only once
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= we;
    end
  end

  always_ff @(posedge CLK) begin
    addr_q  <= addr;
    wdata_q <= wdata;
  end

  assign wr = we && !(wr_q && addr_q == addr && wdata_q == wdata);

  assign wr_ctrl = wdata;
  assign wr_ab   = (addr == ADDR_TACR) || (addr == ADDR_TBCR);

  // per-timer strobes, valid in the write cycle
  assign data_we = {wr && addr == ADDR_TDDR, wr && addr == ADDR_TCDR,
                    wr && addr == ADDR_TBDR, wr && addr == ADDR_TADR};
  assign ctrl_we = {wr && addr == ADDR_TCDCR, wr && addr == ADDR_TCDCR,
                    wr && addr == ADDR_TBCR, wr && addr == ADDR_TACR};
  assign isr_we  = wr && addr == ADDR_ISR;

  assign mode_a     = wr_ctrl.ab.mode;
  assign mode_b     = wr_ctrl.ab.mode;
  // no output reset bit in TCDCR
  assign tout_reset = wr_ab && wr_ctrl.ab.tout_reset;

  // C and D only know delay mode, select 0 stops them
  assign mode_c = {1'b0, wr_ctrl.cd.c_psc};
  assign mode_d = {1'b0, wr_ctrl.cd.d_psc};

  // rebuild TCDCR from both timers
  always_comb begin
    cd_rd = '0;
    cd_rd.cd.c_psc = mode_q_c[PSC_SEL_W-1:0];
    cd_rd.cd.d_psc = mode_q_d[PSC_SEL_W-1:0];
  end

  always_comb begin
    case (addr)
      ADDR_TACR:  rdata = {3'b000, tout[0], mode_q_a};
      ADDR_TBCR:  rdata = {3'b000, tout[1], mode_q_b};
      ADDR_TCDCR: rdata = cd_rd;
      ADDR_TADR:  rdata = count_q_a;
      ADDR_TBDR:  rdata = count_q_b;
      ADDR_TCDR:  rdata = count_q_c;
      ADDR_TDDR:  rdata = count_q_d;
      default:    rdata = irq_status;
    endcase
  end

endmodule

/* src/mfp_timer.sv */
`timescale 1ns/1ps

module mfp_timer #(
  parameter bit HAS_EVENT = 1'b1
) (
  input  logic                             CLK,
  input  logic                             arst_n,
  input  logic                             data_we,
  input  logic [mfp_reg_pkg::DATA_W-1:0]   data,
  input  logic                             ctrl_we,
  input  logic [mfp_timer_pkg::MODE_W-1:0] mode,
  input  logic                             tout_reset,
  input  logic                             xclk,
  input  logic                             trig,
  output logic [mfp_reg_pkg::DATA_W-1:0]   count_q,
  output logic [mfp_timer_pkg::MODE_W-1:0] mode_q,
  output logic                             tout,
  output logic                             timeout
);
  import mfp_timer_pkg::*;

  logic [mfp_reg_pkg::DATA_W-1:0] data_q;
  logic [mfp_reg_pkg::DATA_W-1:0] counter;
  logic                           delay_mode;
  logic                           event_mode;
  logic                           psc_tick;
  logic [1:0]                     trig_sync;
  logic                           trig_prev;
  logic                           trig_rise;
  logic                           count_en;

  // 1001..1111 match neither and hold the counter
  assign delay_mode = (mode_q != MODE_STOP) && !mode_q[MODE_W-1];
  assign event_mode = HAS_EVENT && (mode_q == MODE_EVENT);

  mfp_prescaler u_prescaler (
    .CLK    (CLK),
    .arst_n (arst_n),
    .xclk   (xclk),
    .sel    (mode_q[PSC_SEL_W-1:0]),
    .run    (delay_mode),
    .tick   (psc_tick)
  );

  // trigger input, same treatment as xclk
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      trig_sync <= 2'b00;
      trig_prev <= 1'b0;
    end else begin
      trig_sync <= {trig_sync[0], trig};
      trig_prev <= trig_sync[1];
    end
  end

  assign trig_rise = trig_sync[1] && !trig_prev;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      count_en <= 1'b0;
      timeout  <= 1'b0;
      tout     <= 1'b0;
      data_q   <= '0;
      counter  <= '0;
      mode_q   <= MODE_STOP;
      count_q  <= '0;
    end else begin
      count_en <= (delay_mode && psc_tick) || (event_mode && trig_rise);
      timeout  <= 1'b0;
      // stable copy for the cpu
      count_q  <= counter;

      if (count_en && (delay_mode || event_mode)) begin
        // stepping from 1 is the timeout, 0 counts as 256
        if (counter == 8'd1) begin
          counter <= data_q;
          tout    <= !tout;
          timeout <= 1'b1;
        end else begin
          counter <= counter - 8'd1;
        end
      end

      // a write to the data register restarts the count
      if (data_we) begin
        data_q  <= data;
        counter <= data;
      end

      if (ctrl_we) begin
        mode_q <= mode;
        if (tout_reset) begin
          tout <= 1'b0;
        end
      end
    end
  end

endmodule

/* src/mfp_prescaler.sv */
`timescale 1ns/1ps

module mfp_prescaler (
  input  logic                                CLK,
  input  logic                                arst_n,
  input  logic                                xclk,
  input  logic [mfp_timer_pkg::PSC_SEL_W-1:0] sel,
  input  logic                                run,
  output logic                                tick
);
  import mfp_timer_pkg::*;

  logic [1:0]           xclk_sync;
  logic                 xclk_prev;
  logic                 xclk_rise;
  logic [PSC_DIV_W-1:0] psc_cnt;
  logic                 psc_wrap;

  // xclk is asynchronous to CLK
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      xclk_sync <= 2'b00;
      xclk_prev <= 1'b0;
    end else begin
      xclk_sync <= {xclk_sync[0], xclk};
      xclk_prev <= xclk_sync[1];
    end
  end

  assign xclk_rise = xclk_sync[1] && !xclk_prev;

  // last edge of one divisor period
  assign psc_wrap = (psc_cnt == PSC_DIV[sel] - 8'd1);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      psc_cnt <= '0;
    end else if (!run) begin
      psc_cnt <= '0;
    end else if (xclk_rise) begin
      if (psc_wrap) begin
        psc_cnt <= '0;
      end else begin
        psc_cnt <= psc_cnt + 8'd1;
      end
    end
  end

  assign tick = run && xclk_rise && psc_wrap;

endmodule

/* src/mfp_reg_pkg.sv */
package mfp_reg_pkg;

  // byte wide register port
  localparam int DATA_W = 8;
  localparam int ADDR_W = 3;

  // control registers
  localparam logic [ADDR_W-1:0] ADDR_TACR = 3'd0;
  localparam logic [ADDR_W-1:0] ADDR_TBCR = 3'd1;
  localparam logic [ADDR_W-1:0] ADDR_TCDCR = 3'd2;

  // data registers, counters on read
  localparam logic [ADDR_W-1:0] ADDR_TADR = 3'd3;
  localparam logic [ADDR_W-1:0] ADDR_TBDR = 3'd4;
  localparam logic [ADDR_W-1:0] ADDR_TCDR = 3'd5;
  localparam logic [ADDR_W-1:0] ADDR_TDDR = 3'd6;

  // mask in high nibble, pending in low nibble
  localparam logic [ADDR_W-1:0] ADDR_ISR = 3'd7;

  // layout of TACR and TBCR
  typedef struct packed {
    logic [2:0] unused;
    logic       tout_reset;
    logic [3:0] mode;
  } ctrl_ab_t;

  // layout of TCDCR, one select per timer
  typedef struct packed {
    logic       unused_c;
    logic [2:0] c_psc;
    logic       unused_d;
    logic [2:0] d_psc;
  } ctrl_cd_t;

  // one written control byte, read either way
  typedef union packed {
    ctrl_ab_t ab;
    ctrl_cd_t cd;
  } ctrl_byte_u;

endpackage

/* src/mfp_timer_pkg.sv */
package mfp_timer_pkg;

  // control nibble of one timer
  localparam int MODE_W = 4;

  // timer stopped, counter holds
  localparam logic [MODE_W-1:0] MODE_STOP = 4'b0000;

  // event mode, count trigger edges
  localparam logic [MODE_W-1:0] MODE_EVENT = 4'b1000;

  // codes 0001..0111 are delay mode, low bits select the prescaler
  localparam int PSC_SEL_W = 3;

  // width of a prescale divisor and of the prescale counter
  localparam int PSC_DIV_W = 8;

  // divisor per select value
  localparam logic [PSC_DIV_W-1:0] PSC_DIV [0:(1 << PSC_SEL_W) - 1] = '{
    8'd1,
    8'd4,
    8'd10,
    8'd16,
    8'd50,
    8'd64,
    8'd100,
    8'd200
  };

  // timers A, B, C, D
  localparam int NUM_TIMERS = 4;

endpackage
